// File: dma_rx_egress.sv
// Egress stage of the receive queue
// Optional module header word, then packet body under out_rdy control

module dma_rx_egress #(
   parameter bit         ENABLE_HEADER = 1'b1,
   parameter logic [7:0] PORT_NUMBER   = 8'd0,
   parameter logic [3:0] STAGE_NUMBER  = 4'hf
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              out_rdy,
   input  dma_rx_pkg::fifo_entry_t           word_head,
   input  logic                              word_empty,
   input  logic [dma_rx_pkg::BYTE_LEN_W-1:0] len_head,
   input  logic                              len_empty,
   output logic                              word_rd,
   output logic                              len_rd,
   output dma_rx_pkg::word_t                 out_data,
   output dma_rx_pkg::ctrl_t                 out_ctrl,
   output logic                              out_wr,
   output logic                              ev_removed,
   output logic                              ev_underrun
);

   typedef enum logic {
      ST_HDR,
      ST_BODY
   } state_t;

   state_t                  state;
   state_t                  state_nxt;
   dma_rx_pkg::ioq_hdr_t    hdr;
   dma_rx_pkg::word_t       data_nxt;
   dma_rx_pkg::ctrl_t       ctrl_nxt;
   logic                    go;
   logic                    last_word;

   // A packet is released only once its length is queued
   assign go = out_rdy && !len_empty;
   // Empty word FIFO ends the packet so egress cannot spin on it
   assign last_word = (word_head.ctrl != '0) || word_empty;

   always_comb begin
      hdr          = '0;
      hdr.word_len = dma_rx_pkg::word_len_of(len_head);
      hdr.src_port = PORT_NUMBER;
      hdr.byte_len = len_head;
   end

   ////////////////////////////////////////////////////////////
   // Next output word
   ////////////////////////////////////////////////////////////
   always_comb begin
      state_nxt = state;
      data_nxt  = '0;
      ctrl_nxt  = '0;
      word_rd   = 1'b0;
      len_rd    = 1'b0;
      if (go) begin
         if (ENABLE_HEADER && state == ST_HDR) begin
            data_nxt  = hdr;
            ctrl_nxt  = STAGE_NUMBER;
            state_nxt = ST_BODY;
         end else begin
            data_nxt = word_head.data;
            ctrl_nxt = word_head.ctrl;
            word_rd  = 1'b1;
            if (last_word) begin
               len_rd    = 1'b1;
               state_nxt = ST_HDR;
            end else begin
               state_nxt = ST_BODY;
            end
         end
      end
   end

   assign ev_removed  = len_rd;
   assign ev_underrun = word_rd && word_empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= ST_HDR;
         out_wr <= 1'b0;
      end else begin
         state  <= state_nxt;
         out_wr <= go;
      end
   end

   // Output word register
   always_ff @(posedge clk) begin
      out_data <= data_nxt;
      out_ctrl <= ctrl_nxt;
   end

endmodule

// File: dma_rx_ingress.sv
// DMA ingress stage with length word capture, byte reordering,
// packet tracking, drop and overrun detection

module dma_rx_ingress (
   input  logic                                     clk,
   input  logic                                     reset,
   input  logic                                     rx_queue_en,
   input  logic                                     dma_wr,
   input  dma_rx_pkg::word_t                        dma_wr_data,
   input  dma_rx_pkg::ctrl_t                        dma_wr_ctrl,
   input  logic                                     flush,
   input  logic                                     word_fifo_full,
   output logic                                     word_wr,
   output dma_rx_pkg::fifo_entry_t                  word_wr_data,
   output logic                                     len_wr,
   output logic [dma_rx_pkg::BYTE_LEN_W-1:0]        len_wr_data,
   output logic                                     ev_stored,
   output logic                                     ev_dropped,
   output logic                                     ev_overrun,
   output logic [dma_rx_pkg::BYTE_LEN_W-1:0]        pkt_byte_len,
   output logic [dma_rx_pkg::WORD_LEN_W-1:0]        pkt_word_len
);

   dma_rx_pkg::dma_word_u               dma_word;
   dma_rx_pkg::fifo_entry_t             swapped;
   logic [dma_rx_pkg::BYTE_LEN_W-1:0]   cur_len;
   logic                                in_pkt;
   logic                                dropping;
   logic                                is_last;
   logic                                len_word;

   assign dma_word = dma_rx_pkg::dma_word_u'(dma_wr_data);
   assign is_last  = (dma_wr_ctrl != '0);
   // First write outside a packet carries the byte length
   assign len_word = dma_wr && !in_pkt && !flush;

   // Little-endian host words to big-endian datapath order
   always_comb begin
      swapped.data = {<<8{dma_word.raw}};
      swapped.ctrl = {<<{dma_wr_ctrl}};
   end

   ////////////////////////////////////////////////////////////
   // Packet tracking and FIFO write strobes
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         in_pkt       <= 1'b0;
         dropping     <= 1'b0;
         word_wr      <= 1'b0;
         len_wr       <= 1'b0;
         ev_stored    <= 1'b0;
         ev_dropped   <= 1'b0;
         ev_overrun   <= 1'b0;
         pkt_byte_len <= '0;
         pkt_word_len <= '0;
      end else begin
         word_wr    <= 1'b0;
         len_wr     <= 1'b0;
         ev_stored  <= 1'b0;
         ev_dropped <= 1'b0;
         ev_overrun <= 1'b0;
         if (flush) begin
            // Timeout so the next write starts a new packet
            in_pkt   <= 1'b0;
            dropping <= 1'b0;
         end else if (len_word) begin
            in_pkt   <= 1'b1;
            dropping <= !rx_queue_en;
            if (rx_queue_en) begin
               pkt_byte_len <= dma_word.len.byte_len;
               pkt_word_len <= dma_rx_pkg::word_len_of(dma_word.len.byte_len);
            end
         end else if (dma_wr) begin
            if (is_last) begin
               in_pkt   <= 1'b0;
               dropping <= 1'b0;
            end
            if (dropping) begin
               ev_dropped <= is_last;
            end else if (word_fifo_full) begin
               // Word is lost; length only follows a stored last word
               ev_overrun <= 1'b1;
            end else begin
               word_wr   <= 1'b1;
               len_wr    <= is_last;
               ev_stored <= is_last;
            end
         end
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (len_word && rx_queue_en)
         cur_len <= dma_word.len.byte_len;
      word_wr_data <= swapped;
      len_wr_data  <= cur_len;
   end

endmodule

// File: dma_rx_pkg.sv
// Shared types for the host-to-device DMA receive queue
// Word, header and event structs plus the byte-to-word length helper

package dma_rx_pkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////
   localparam int BYTE_LEN_W = 12;
   localparam int WORD_LEN_W = 10;
   localparam int CNT_W      = 16;

   typedef logic [31:0] word_t;
   // Nonzero marks the last word, one bit per valid end byte
   typedef logic [3:0]  ctrl_t;

   // First DMA word of a packet, seen as a length
   typedef struct packed {
      logic [31-BYTE_LEN_W:0] unused;
      logic [BYTE_LEN_W-1:0]  byte_len;
   } len_hdr_t;

   // Same DMA word, raw data or length depending on position
   typedef union packed {
      word_t    raw;
      len_hdr_t len;
   } dma_word_u;

   // Word FIFO entry, 36 bits
   typedef struct packed {
      ctrl_t ctrl;
      word_t data;
   } fifo_entry_t;

   // Module header word sent ahead of each packet
   typedef struct packed {
      logic [WORD_LEN_W-1:0] word_len;
      logic [7:0]            src_port;
      logic [1:0]            pad;
      logic [BYTE_LEN_W-1:0] byte_len;
   } ioq_hdr_t;

   // One-cycle event strobes for the stats stage
   typedef struct packed {
      logic stored;
      logic removed;
      logic dropped;
      logic overrun;
      logic underrun;
      logic timeout;
   } rx_event_t;

   // Byte length to 32-bit word count, rounded up
   function automatic logic [WORD_LEN_W-1:0] word_len_of(input logic [BYTE_LEN_W-1:0] byte_len);
      return byte_len[BYTE_LEN_W-1:2] + WORD_LEN_W'(|byte_len[1:0]);
   endfunction

endpackage

// File: dma_rx_queue_top.sv
// Host-to-device DMA receive queue top level
// Ingress, word and length FIFOs, watchdog, egress and stats

module dma_rx_queue_top #(
   parameter int         WATCHDOG_TIMEOUT = 1000,
   parameter bit         ENABLE_HEADER    = 1'b1,
   parameter logic [7:0] PORT_NUMBER      = 8'd0,
   parameter logic [3:0] STAGE_NUMBER     = 4'hf,
   parameter int         FIFO_DEPTH_BITS  = 9
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              dma_wr,
   input  dma_rx_pkg::word_t                 dma_wr_data,
   input  dma_rx_pkg::ctrl_t                 dma_wr_ctrl,
   input  logic                              rx_queue_en,
   input  logic                              out_rdy,
   output logic                              dma_nearly_full,
   output dma_rx_pkg::word_t                 out_data,
   output dma_rx_pkg::ctrl_t                 out_ctrl,
   output logic                              out_wr,
   output logic [dma_rx_pkg::BYTE_LEN_W-1:0] pkt_byte_len,
   output logic [dma_rx_pkg::WORD_LEN_W-1:0] pkt_word_len,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_stored,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_removed,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_dropped,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_overrun,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_underrun,
   output logic [dma_rx_pkg::CNT_W-1:0]      cnt_timeout
);

   dma_rx_pkg::fifo_entry_t              word_wr_data, word_head;
   logic [dma_rx_pkg::BYTE_LEN_W-1:0]    len_wr_data, len_head;
   logic                                 word_wr, word_rd, word_empty, word_full, word_nf;
   logic                                 len_wr, len_rd, len_empty, len_nf;
   logic                                 flush;
   dma_rx_pkg::rx_event_t                events;

   dma_rx_ingress ingress (
      .clk, .reset, .rx_queue_en, .dma_wr, .dma_wr_data, .dma_wr_ctrl, .flush,
      .word_fifo_full(word_full), .word_wr, .word_wr_data, .len_wr, .len_wr_data,
      .ev_stored(events.stored), .ev_dropped(events.dropped),
      .ev_overrun(events.overrun), .pkt_byte_len, .pkt_word_len
   );

   // Word FIFO, data and reordered ctrl
   sync_fwft_fifo #(.WIDTH($bits(dma_rx_pkg::fifo_entry_t)), .DEPTH_BITS(FIFO_DEPTH_BITS)) word_fifo (
      .clk, .reset, .flush, .wr_en(word_wr), .din(word_wr_data), .rd_en(word_rd),
      .dout(word_head), .empty(word_empty), .full(word_full), .nearly_full(word_nf)
   );

   // Length FIFO, as deep as the word FIFO since each packet holds a word
   sync_fwft_fifo #(.WIDTH(dma_rx_pkg::BYTE_LEN_W), .DEPTH_BITS(FIFO_DEPTH_BITS)) len_fifo (
      .clk, .reset, .flush, .wr_en(len_wr), .din(len_wr_data), .rd_en(len_rd),
      .dout(len_head), .empty(len_empty), .full(), .nearly_full(len_nf)
   );

   dma_rx_watchdog #(.TIMEOUT(WATCHDOG_TIMEOUT)) watchdog (
      .clk, .reset, .word_wr, .word_rd, .word_empty, .len_empty, .flush
   );

   dma_rx_egress #(
      .ENABLE_HEADER(ENABLE_HEADER), .PORT_NUMBER(PORT_NUMBER), .STAGE_NUMBER(STAGE_NUMBER)
   ) egress (
      .clk, .reset, .out_rdy, .word_head, .word_empty, .len_head, .len_empty,
      .word_rd, .len_rd, .out_data, .out_ctrl, .out_wr,
      .ev_removed(events.removed), .ev_underrun(events.underrun)
   );

   // Timeout event is the flush pulse itself
   assign events.timeout = flush;

   dma_rx_stats stats (
      .clk, .reset, .events, .cnt_stored, .cnt_removed, .cnt_dropped,
      .cnt_overrun, .cnt_underrun, .cnt_timeout
   );

   // DMA side has no back-pressure, only this flag
   always_ff @(posedge clk) begin
      if (reset)
         dma_nearly_full <= 1'b0;
      else
         dma_nearly_full <= word_nf || len_nf;
   end

endmodule

// File: dma_rx_stats.sv
// Event counters of the receive queue
// Registered event strobes feeding saturating counters

module dma_rx_stats (
   input  logic                         clk,
   input  logic                         reset,
   input  dma_rx_pkg::rx_event_t        events,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_stored,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_removed,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_dropped,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_overrun,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_underrun,
   output logic [dma_rx_pkg::CNT_W-1:0] cnt_timeout
);

   localparam int NUM_EV = $bits(dma_rx_pkg::rx_event_t);

   dma_rx_pkg::rx_event_t        ev_q;
   logic [NUM_EV-1:0]            ev_bits;
   logic [dma_rx_pkg::CNT_W-1:0] cnt [NUM_EV];

   // Bit order follows the struct, stored is the top bit
   assign ev_bits = ev_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         ev_q <= '0;
         for (int i = 0; i < NUM_EV; i++)
            cnt[i] <= '0;
      end else begin
         ev_q <= events;
         // Saturate at all ones
         for (int i = 0; i < NUM_EV; i++) begin
            if (ev_bits[i] && cnt[i] != '1)
               cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   assign cnt_stored   = cnt[5];
   assign cnt_removed  = cnt[4];
   assign cnt_dropped  = cnt[3];
   assign cnt_overrun  = cnt[2];
   assign cnt_underrun = cnt[1];
   assign cnt_timeout  = cnt[0];

endmodule

// File: dma_rx_watchdog.sv
// Idle watchdog for the receive queue
// Flushes a partial packet that sits in the word FIFO too long

module dma_rx_watchdog #(
   parameter int TIMEOUT = 1000
) (
   input  logic clk,
   input  logic reset,
   input  logic word_wr,
   input  logic word_rd,
   input  logic word_empty,
   input  logic len_empty,
   output logic flush
);

   localparam int TIMER_W = $clog2(TIMEOUT + 1);

   logic [TIMER_W-1:0] timer;
   logic               activity;
   logic               expired;

   // Any FIFO traffic restarts the count
   assign activity = word_wr || word_rd;
   assign expired  = (timer == '0);

   ////////////////////////////////////////////////////////////
   // Countdown and timeout pulse
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset || activity) begin
         timer <= TIMER_W'(TIMEOUT);
         flush <= 1'b0;
      end else begin
         // Only runs while words are waiting
         if (!word_empty && !expired)
            timer <= timer - 1'b1;
         // Data present but no complete packet behind it
         // Single cycle, the flush empties the FIFO
         flush <= expired && !word_empty && len_empty && !flush;
      end
   end

endmodule

// File: project.f
dma_rx_pkg.sv
sync_fwft_fifo.sv
dma_rx_ingress.sv
dma_rx_watchdog.sv
dma_rx_egress.sv
dma_rx_stats.sv
dma_rx_queue_top.sv
tb_dma_rx_queue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA receive queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_dma_rx_queue -f project.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test completed successfully" "$log"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation did not pass, see $log"
   exit 1
fi

// File: sync_fwft_fifo.sv
// Synchronous first-word-fall-through FIFO with flush and nearly-full
// Head entry is always presented on dout

module sync_fwft_fifo #(
   parameter int WIDTH              = 36,
   parameter int DEPTH_BITS         = 6,
   parameter int NEARLY_FULL_MARGIN = 4
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             flush,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] din,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             full,
   output logic             nearly_full
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // Writes into a truly full buffer and reads of an empty one are ignored
   assign do_wr = wr_en && (count != (DEPTH_BITS + 1)'(DEPTH));
   assign do_rd = rd_en && (count != '0);

   // Pointers and fill level, flush behaves like reset
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (DEPTH_BITS + 1)'(do_wr) - (DEPTH_BITS + 1)'(do_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   // Fall-through head
   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);
   // One slot held back for a write already in flight from a registered writer
   assign full        = (count >= (DEPTH_BITS + 1)'(DEPTH - 1));
   assign nearly_full = (count >= (DEPTH_BITS + 1)'(DEPTH - NEARLY_FULL_MARGIN));

endmodule

// File: tb_dma_rx_queue.sv
// Directed testbench for the DMA receive queue
// Reference model of output words and event counters

module tb_dma_rx_queue;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int         WATCHDOG_TIMEOUT = 64;
   localparam logic [7:0] PORT_NUMBER      = 8'd3;
   localparam logic [3:0] STAGE_NUMBER     = 4'hf;
   localparam int         FIFO_DEPTH_BITS  = 6;
   localparam int         FIFO_DEPTH       = 2 ** FIFO_DEPTH_BITS;
   // About 700 cycles of traffic over all tests, wide margin
   localparam int         CYCLE_LIMIT      = 4000;

   logic        clk = 1'b0;
   logic        reset;
   logic        dma_wr;
   logic [31:0] dma_wr_data;
   logic [3:0]  dma_wr_ctrl;
   logic        rx_queue_en;
   logic        out_rdy;
   logic        dma_nearly_full;
   logic [31:0] out_data;
   logic [3:0]  out_ctrl;
   logic        out_wr;
   logic [11:0] pkt_byte_len;
   logic [9:0]  pkt_word_len;
   logic [15:0] cnt_stored;
   logic [15:0] cnt_removed;
   logic [15:0] cnt_dropped;
   logic [15:0] cnt_overrun;
   logic [15:0] cnt_underrun;
   logic [15:0] cnt_timeout;

   // Model queues, {ctrl, data} per output word
   logic [35:0] exp_q[$];
   int          exp_len_q[$];
   logic [35:0] got_q[$];
   integer      seed;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          pkt_total = 0;
   int          rdy_violations = 0;
   logic        rdy_prev = 1'b0;
   logic        rdy_random;

   dma_rx_queue_top #(
      .WATCHDOG_TIMEOUT(WATCHDOG_TIMEOUT), .ENABLE_HEADER(1'b1), .PORT_NUMBER(PORT_NUMBER),
      .STAGE_NUMBER(STAGE_NUMBER), .FIFO_DEPTH_BITS(FIFO_DEPTH_BITS)
   ) uut (
      .clk, .reset, .dma_wr, .dma_wr_data, .dma_wr_ctrl, .rx_queue_en, .out_rdy,
      .dma_nearly_full, .out_data, .out_ctrl, .out_wr, .pkt_byte_len, .pkt_word_len,
      .cnt_stored, .cnt_removed, .cnt_dropped, .cnt_overrun, .cnt_underrun, .cnt_timeout
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Test failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output monitor, sampled mid-cycle
   ////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      if (out_wr) begin
         got_q.push_back({out_ctrl, out_data});
         if (!rdy_prev) begin
            rdy_violations = rdy_violations + 1;
            $display("out_wr was raised after a cycle with out_rdy low at %0t", $time);
         end
      end
      rdy_prev = out_rdy;
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   // Little-endian host word to big-endian datapath word
   function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
      logic [31:0] r;
      for (int i = 0; i < 4; i++)
         r[8*i +: 8] = w[8*(3-i) +: 8];
      return r;
   endfunction

   function automatic logic [3:0] reverse_bits(input logic [3:0] c);
      logic [3:0] r;
      for (int i = 0; i < 4; i++)
         r[i] = c[3-i];
      return r;
   endfunction

   // Header: word count rounded up, source port, byte count
   function automatic logic [35:0] header_entry(input int byte_len);
      logic [9:0]  words;
      logic [11:0] bytes;
      words = 10'((byte_len + 3) / 4);
      bytes = 12'(byte_len);
      return {STAGE_NUMBER, words, PORT_NUMBER, 2'b00, bytes};
   endfunction

   task automatic idle_cycles(input int n);
      dma_wr = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Length word then data words, last word flags its final valid byte
   // Without complete the last word is held back
   task automatic send_packet(input int byte_len, inout integer pkt_seed, input bit complete);
      int          n_words;
      int          n_sent;
      int          tail;
      bit          record;
      logic [31:0] data;
      logic [3:0]  ctrl;
      n_words = (byte_len + 3) / 4;
      n_sent  = complete ? n_words : n_words - 1;
      tail    = byte_len - 4 * (n_words - 1);
      // A packet opened with the queue disabled never comes out
      record  = complete && rx_queue_en;
      if (record) begin
         exp_q.push_back(header_entry(byte_len));
         exp_len_q.push_back(n_words + 1);
         pkt_total++;
      end
      // Upper bits of the length word are junk
      data        = $random(pkt_seed);
      dma_wr      = 1'b1;
      dma_wr_data = {data[31:12], 12'(byte_len)};
      dma_wr_ctrl = 4'h0;
      @(posedge clk);
      #1;
      for (int i = 0; i < n_sent; i++) begin
         data        = $random(pkt_seed);
         ctrl        = (i == n_words - 1) ? 4'(1 << (tail - 1)) : 4'h0;
         dma_wr_data = data;
         dma_wr_ctrl = ctrl;
         if (record)
            exp_q.push_back({reverse_bits(ctrl), reverse_bytes(data)});
         @(posedge clk);
         #1;
      end
      dma_wr      = 1'b0;
      dma_wr_ctrl = 4'h0;
   endtask

   // Waits for the next model packet, toggling out_rdy when asked
   task automatic expect_packet();
      int          n_words;
      int          rnd;
      logic [35:0] got;
      logic [35:0] exp;
      if (exp_len_q.size() == 0) begin
         errors++;
         $display("No packet left in the model to compare against");
         return;
      end
      n_words = exp_len_q.pop_front();
      while (got_q.size() < n_words) begin
         if (rdy_random) begin
            rnd     = $random(seed);
            out_rdy = rnd[0];
         end
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < n_words; i++) begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         check_value("out_data", 64'(got[31:0]), 64'(exp[31:0]));
         check_value("out_ctrl", 64'(got[35:32]), 64'(exp[35:32]));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////
   task automatic single_packet();
      send_packet(13, seed, 1'b1);
      check_value("pkt_byte_len", 64'(pkt_byte_len), 64'd13);
      check_value("pkt_word_len", 64'(pkt_word_len), 64'd4);
      expect_packet();
   endtask

   task automatic back_to_back();
      int lens[5] = '{4, 7, 22, 1, 40};
      for (int i = 0; i < 5; i++)
         send_packet(lens[i], seed, 1'b1);
      repeat (5)
         expect_packet();
      idle_cycles(4);
      check_value("cnt_stored", 64'(cnt_stored), 64'(pkt_total));
      check_value("cnt_removed", 64'(cnt_removed), 64'(pkt_total));
   endtask

   task automatic back_pressure();
      // Words pile up, then drain under a random out_rdy
      out_rdy = 1'b0;
      send_packet(17, seed, 1'b1);
      send_packet(33, seed, 1'b1);
      send_packet(8, seed, 1'b1);
      rdy_random = 1'b1;
      repeat (3)
         expect_packet();
      rdy_random = 1'b0;
      out_rdy    = 1'b1;
      idle_cycles(4);
      check_value("cnt_underrun", 64'(cnt_underrun), 64'd0);
   endtask

   task automatic watchdog_flush();
      send_packet(40, seed, 1'b0);
      idle_cycles(100);
      check_value("output words", 64'(got_q.size()), 64'd0);
      check_value("cnt_timeout", 64'(cnt_timeout), 64'd1);
      send_packet(26, seed, 1'b1);
      expect_packet();
   endtask

   task automatic disabled_drop();
      rx_queue_en = 1'b0;
      send_packet(20, seed, 1'b1);
      rx_queue_en = 1'b1;
      send_packet(9, seed, 1'b1);
      expect_packet();
      idle_cycles(4);
      check_value("cnt_dropped", 64'(cnt_dropped), 64'd1);
      check_value("pkt_byte_len", 64'(pkt_byte_len), 64'd9);
   endtask

   task automatic fifo_overrun();
      int n_words;
      n_words = FIFO_DEPTH + 6;
      out_rdy = 1'b0;
      send_packet(4 * n_words, seed, 1'b1);
      // Last word is lost, so the packet never completes
      exp_q.delete();
      exp_len_q.delete();
      pkt_total--;
      check_value("dma_nearly_full", 64'(dma_nearly_full), 64'd1);
      idle_cycles(4);
      check_value("cnt_overrun", 64'(cnt_overrun), 64'(n_words - FIFO_DEPTH));
      // Stuck words cleared by the watchdog
      idle_cycles(WATCHDOG_TIMEOUT + 36);
      check_value("cnt_timeout", 64'(cnt_timeout), 64'd2);
      check_value("dma_nearly_full", 64'(dma_nearly_full), 64'd0);
      check_value("output words", 64'(got_q.size()), 64'd0);
      out_rdy = 1'b1;
      send_packet(30, seed, 1'b1);
      expect_packet();
   endtask

   initial begin
      seed        = 97351;
      rdy_random  = 1'b0;
      reset       = 1'b1;
      dma_wr      = 1'b0;
      dma_wr_data = '0;
      dma_wr_ctrl = '0;
      rx_queue_en = 1'b1;
      out_rdy     = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value("out_wr", 64'(out_wr), 64'd0);
      check_value("dma_nearly_full", 64'(dma_nearly_full), 64'd0);
      check_value("cnt_stored", 64'(cnt_stored), 64'd0);
      single_packet();
      back_to_back();
      back_pressure();
      watchdog_flush();
      disabled_drop();
      fifo_overrun();
      idle_cycles(4);
      check_value("cnt_stored", 64'(cnt_stored), 64'(pkt_total));
      check_value("cnt_removed", 64'(cnt_removed), 64'(pkt_total));
      check_value("cnt_underrun", 64'(cnt_underrun), 64'd0);
      check_value("output words", 64'(got_q.size()), 64'd0);
      check_value("out_wr after out_rdy low", 64'(rdy_violations), 64'd0);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule
